/* build.f */
+incdir+source
+incdir+bench
source/trace_pkg.sv
source/trace_packetizer.sv
source/packet_fifo.sv
source/word_streamer.sv
source/trace_compressor.sv
bench/tb_trace_compressor.sv

/* run.sh */
#!/bin/sh
# build the trace compressor testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_trace_compressor \
    -Mdir obj_dir -o sim_trace_compressor
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_trace_compressor
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0

/* bench/trace_ref.svh */
// ========================================
// trace reference model
// expected output words for an instruction
// list, and typed compare tasks
// ========================================
`ifndef TRACE_REF_SVH
`define TRACE_REF_SVH

`include "trace_config.svh"

typedef logic [31:0] word_q_t[$];
typedef bit flag_q_t[$];

// walks the retired instructions in order and emits the words of each packet
// a max_packets of 0 keeps every packet
function automatic word_q_t expected_words(input word_q_t addrs, input word_q_t instrs,
                                           input flag_q_t comps, input int max_packets);
    word_q_t                   words;
    logic [`TRACE_MAP_LEN-1:0] map;
    logic [31:0]               fall_through;
    logic [1:0]                fmt;
    int                        cnt;
    int                        packets;
    bit                        prev_branch;
    bit                        prev_jalr;
    map          = '0;
    fall_through = '0;
    cnt          = 0;
    packets      = 0;
    prev_branch  = 1'b0;
    prev_jalr    = 1'b0;
    for (int k = 0; k < addrs.size(); k++) begin
        fmt = 2'd0;
        // a branch was taken when the next address is not its fall-through
        if (prev_branch) begin
            map[cnt] = addrs[k] != fall_through;
            cnt++;
        end
        if (cnt == `TRACE_MAP_LEN) begin
            fmt = trace_pkg::FMT_BRANCH;
        end else if (k == 0) begin
            fmt = trace_pkg::FMT_SYNC;
        end else if (prev_jalr) begin
            fmt = trace_pkg::FMT_ADDR;
        end
        if (fmt != 2'd0 && (max_packets == 0 || packets < max_packets)) begin
            words.push_back({25'd0, 5'(cnt), fmt});
            if (fmt != trace_pkg::FMT_SYNC) begin
                words.push_back({1'b0, map});
            end
            if (fmt != trace_pkg::FMT_BRANCH) begin
                words.push_back(addrs[k]);
            end
        end
        if (fmt != 2'd0) begin
            packets++;
        end
        if (fmt == trace_pkg::FMT_BRANCH || fmt == trace_pkg::FMT_ADDR) begin
            map = '0;
            cnt = 0;
        end
        prev_branch  = instrs[k][6:0] == trace_pkg::OPCODE_BRANCH;
        prev_jalr    = instrs[k][6:0] == trace_pkg::OPCODE_JALR;
        fall_through = addrs[k] + (comps[k] ? 32'd2 : 32'd4);
    end
    return words;
endfunction

task automatic check_word(input string name, input logic [trace_pkg::WORD_LEN-1:0] got,
                          input logic [trace_pkg::WORD_LEN-1:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

`endif

/* bench/tb_trace_compressor.sv */
// ========================================
// trace compressor testbench
// instruction programs, credit return and
// word by word checking against a model
// ========================================
`timescale 1ns/1ns
`include "trace_config.svh"

`default_nettype none

module tb_trace_compressor;

    localparam logic [31:0] INSTR_ADDI = 32'h0000_0013;
    localparam logic [31:0] INSTR_BEQ  = 32'h0020_8463;
    localparam logic [31:0] INSTR_JALR = 32'h0000_8067;
    localparam int CREDIT_PROG_LEN = 20;
    localparam int OVF_PROG_LEN    = `TRACE_FIFO_DEPTH + 3;
    // map program 33 and jalr program 7 instructions
    localparam int TOTAL_INSTR     = 33 + 7 + CREDIT_PROG_LEN + OVF_PROG_LEN;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_INSTR + 200;

    logic                           clk_gated;
    logic                           rst_ni;
    logic                           ivalid_i;
    logic [31:0]                    iaddr_i;
    logic [31:0]                    instr_i;
    logic                           compressed_i;
    logic                           credit_i = 1'b0;
    logic [trace_pkg::WORD_LEN-1:0] word_o;
    logic                           word_valid_o;
    logic                           overflow_o;

    integer seed = 32'h86ca_5c7d;
    bit     hold_credits = 1'b0;
    int     words_seen;
    int     outstanding;
    int     owed;
    int     delay;
    logic [31:0] pc;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    `include "trace_ref.svh"

    word_q_t prog_addr;
    word_q_t prog_instr;
    flag_q_t prog_comp;
    word_q_t expect_q;

    trace_compressor dut (
        .clk_gated    (clk_gated),
        .rst_ni       (rst_ni),
        .ivalid_i     (ivalid_i),
        .iaddr_i      (iaddr_i),
        .instr_i      (instr_i),
        .compressed_i (compressed_i),
        .credit_i     (credit_i),
        .word_o       (word_o),
        .word_valid_o (word_valid_o),
        .overflow_o   (overflow_o)
    );

    initial begin
        clk_gated = 1'b0;
        forever #5 clk_gated = ~clk_gated;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic start_program(input logic [31:0] start_pc);
        prog_addr.delete();
        prog_instr.delete();
        prog_comp.delete();
        pc = start_pc;
    endtask

    // taken only matters for branches, a jalr jumps somewhere random
    task automatic add_instr(input logic [31:0] encoding, input bit comp, input bit taken);
        prog_addr.push_back(pc);
        prog_instr.push_back(encoding);
        prog_comp.push_back(comp);
        if (encoding == INSTR_JALR) begin
            pc = $random(seed) & 32'hffff_fffe;
        end else if (taken) begin
            pc = pc + 32'h0000_0040;
        end else begin
            pc = pc + (comp ? 32'd2 : 32'd4);
        end
    endtask

    task automatic apply_reset(input int max_packets);
        @(posedge clk_gated);
        rst_ni <= 1'b0;
        repeat (8) @(posedge clk_gated);
        rst_ni   <= 1'b1;
        expect_q = expected_words(prog_addr, prog_instr, prog_comp, max_packets);
    endtask

    task automatic drive_program(input int min_gap, input int max_gap);
        int gap;
        for (int k = 0; k < prog_addr.size(); k++) begin
            @(posedge clk_gated);
            ivalid_i     <= 1'b1;
            iaddr_i      <= prog_addr[k];
            instr_i      <= prog_instr[k];
            compressed_i <= prog_comp[k];
            gap = min_gap + rand_below(max_gap - min_gap + 1);
            repeat (gap) begin
                @(posedge clk_gated);
                ivalid_i <= 1'b0;
            end
        end
        @(posedge clk_gated);
        ivalid_i <= 1'b0;
    endtask

    // a few extra cycles let a stray word show up
    task automatic wait_words();
        wait (words_seen == expect_q.size());
        repeat (10) @(posedge clk_gated);
    endtask

    // receiver side, one credit back per word after a random pause
    always @(posedge clk_gated) begin
        if (!rst_ni) begin
            owed  = 0;
            delay = 0;
            credit_i <= 1'b0;
        end else begin
            credit_i <= 1'b0;
            if (word_valid_o) begin
                owed++;
            end
            if (owed > 0 && !hold_credits) begin
                if (delay == 0) begin
                    credit_i <= 1'b1;
                    owed--;
                    delay = rand_below(6);
                end else begin
                    delay--;
                end
            end
        end
    end

    always @(posedge clk_gated) begin
        if (!rst_ni) begin
            words_seen  = 0;
            outstanding = 0;
        end else if (word_valid_o && words_seen >= expect_q.size()) begin
            report_failure("a word arrived after the last expected word");
        end else if (outstanding + int'(word_valid_o) - int'(credit_i) > `TRACE_CREDITS) begin
            report_failure("more words are outstanding than the receiver has credits for");
        end else begin
            if (word_valid_o) begin
                check_word("word_o", word_o, expect_q[words_seen]);
                words_seen++;
            end
            outstanding = outstanding + int'(word_valid_o) - int'(credit_i);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_gated);
        report_failure($sformatf("the run timed out after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        rst_ni       <= 1'b0;
        ivalid_i     <= 1'b0;
        iaddr_i      <= '0;
        instr_i      <= '0;
        compressed_i <= 1'b0;

        // sync packet, then a full map of random outcomes
        start_program(32'h8000_0000);
        add_instr(INSTR_ADDI, 1'b0, 1'b0);
        for (int i = 0; i < `TRACE_MAP_LEN; i++) begin
            add_instr(INSTR_BEQ, rand_below(2) == 1, rand_below(2) == 1);
        end
        add_instr(INSTR_ADDI, 1'b0, 1'b0);
        apply_reset(0);
        drive_program(0, 2);
        wait_words();
        check_flag("overflow_o", overflow_o, 1'b0);

        // pending branches go out with the jalr target, compressed ones step by 2
        start_program(32'h0000_1000);
        add_instr(INSTR_ADDI, 1'b0, 1'b0);
        add_instr(INSTR_BEQ, 1'b1, 1'b0);
        add_instr(INSTR_BEQ, 1'b1, 1'b1);
        add_instr(INSTR_BEQ, 1'b0, 1'b1);
        add_instr(INSTR_JALR, 1'b0, 1'b0);
        add_instr(INSTR_ADDI, 1'b0, 1'b0);
        add_instr(INSTR_ADDI, 1'b1, 1'b0);
        apply_reset(0);
        drive_program(0, 2);
        wait_words();
        check_flag("overflow_o", overflow_o, 1'b0);

        // only the reset credits may be spent while the receiver holds back
        // at most three more jumps, so every packet fits while credits are held
        start_program(32'h0040_0000);
        add_instr(INSTR_ADDI, 1'b0, 1'b0);
        add_instr(INSTR_JALR, 1'b0, 1'b0);
        for (int i = 2; i < CREDIT_PROG_LEN; i++) begin
            add_instr((i % 6 == 0 && rand_below(2) == 1) ? INSTR_JALR : INSTR_BEQ,
                      rand_below(2) == 1, rand_below(2) == 1);
        end
        hold_credits = 1'b1;
        apply_reset(0);
        drive_program(0, 2);
        repeat (40) @(posedge clk_gated);
        @(negedge clk_gated);
        check_flag("word_valid_o", word_valid_o, 1'b0);
        if (words_seen != `TRACE_CREDITS) begin
            report_failure("the number of words sent without returned credits is wrong");
        end
        hold_credits = 1'b0;
        wait_words();
        check_flag("overflow_o", overflow_o, 1'b0);

        // reset credits cover the sync packet and part of the first ADDR packet
        // the streamer keeps that packet and the FIFO fills up behind it
        start_program(32'h0010_0000);
        for (int i = 0; i < OVF_PROG_LEN; i++) begin
            add_instr(INSTR_JALR, 1'b0, 1'b0);
        end
        hold_credits = 1'b1;
        apply_reset(`TRACE_FIFO_DEPTH + 2);
        drive_program(8, 8);
        repeat (20) @(posedge clk_gated);
        @(negedge clk_gated);
        check_flag("overflow_o", overflow_o, 1'b1);
        hold_credits = 1'b0;
        wait_words();
        check_flag("overflow_o", overflow_o, 1'b1);

        if (words_seen != expect_q.size()) begin
            report_failure("the run ended before all expected words arrived");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* source/trace_compressor.sv */
// ========================================
// trace compressor top level
// packetizer, packet FIFO and word streamer
// ========================================
`timescale 1ns/1ns
`include "trace_config.svh"

`default_nettype none

module trace_compressor (
    input  logic                           clk_gated,
    input  logic                           rst_ni,
    input  logic                           ivalid_i,
    input  logic [31:0]                    iaddr_i,
    input  logic [31:0]                    instr_i,
    input  logic                           compressed_i,
    input  logic                           credit_i,
    output logic [trace_pkg::WORD_LEN-1:0] word_o,
    output logic                           word_valid_o,
    output logic                           overflow_o
);

    // producer to buffer, no back-pressure
    trace_pkg::packet_t pkt;
    logic               pkt_valid;

    // buffer to streamer pull
    trace_pkg::packet_t head;
    logic               head_valid;
    logic               pop;

    trace_packetizer i_packetizer (
        .clk_gated    (clk_gated),
        .rst_ni       (rst_ni),
        .ivalid_i     (ivalid_i),
        .iaddr_i      (iaddr_i),
        .instr_i      (instr_i),
        .compressed_i (compressed_i),
        .pkt_o        (pkt),
        .pkt_valid_o  (pkt_valid)
    );

    packet_fifo #(
        .payload_t (trace_pkg::packet_t),
        .DEPTH     (`TRACE_FIFO_DEPTH)
    ) i_packet_fifo (
        .clk_gated    (clk_gated),
        .rst_ni       (rst_ni),
        .push_i       (pkt_valid),
        .data_i       (pkt),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid),
        .overflow_o   (overflow_o)
    );

    word_streamer i_word_streamer (
        .clk_gated    (clk_gated),
        .rst_ni       (rst_ni),
        .head_i       (head),
        .head_valid_i (head_valid),
        .credit_i     (credit_i),
        .pop_o        (pop),
        .word_o       (word_o),
        .word_valid_o (word_valid_o)
    );

endmodule

`default_nettype wire

/* source/word_streamer.sv */
// ========================================
// word streamer
// splits each packet into 32-bit words and
// sends them under credit flow control
// ========================================
`timescale 1ns/1ns
`include "trace_config.svh"

`default_nettype none

module word_streamer (
    input  logic                          clk_gated,
    input  logic                          rst_ni,
    input  trace_pkg::packet_t            head_i,
    input  logic                          head_valid_i,
    input  logic                          credit_i,
    output logic                          pop_o,
    output logic [trace_pkg::WORD_LEN-1:0] word_o,
    output logic                          word_valid_o
);

    localparam int unsigned CREDIT_W = $clog2(`TRACE_CREDITS + 1);

    trace_pkg::packet_t               pkt_q;
    logic                             busy_q;
    logic [1:0]                       idx_q;
    logic [1:0]                       last_idx;
    logic                             last_word;
    logic [CREDIT_W-1:0]              credit_q;
    logic [trace_pkg::WORD_LEN-1:0]   header_word;
    logic [trace_pkg::WORD_LEN-1:0]   map_word;

    // header carries format in [1:0] and branch count in [6:2]
    assign header_word = {{(trace_pkg::WORD_LEN - 2 - trace_pkg::MAP_CNT_W){1'b0}},
                          pkt_q.branch_cnt, pkt_q.format};
    assign map_word    = {{(trace_pkg::WORD_LEN - `TRACE_MAP_LEN){1'b0}}, pkt_q.branch_map};

    // ADDR packets carry header, map and address, the others two words
    assign last_idx  = (pkt_q.format == trace_pkg::FMT_ADDR) ? 2'd2 : 2'd1;
    assign last_word = idx_q == last_idx;

    always_comb begin
        case (idx_q)
            2'd0:    word_o = header_word;
            2'd1:    word_o = (pkt_q.format == trace_pkg::FMT_SYNC) ? pkt_q.addr : map_word;
            2'd2:    word_o = pkt_q.addr;
            default: word_o = '0;
        endcase
    end

    assign word_valid_o = busy_q && (credit_q != '0);

    // next packet is taken once the current one is fully sent
    assign pop_o = !busy_q && head_valid_i;

    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            idx_q    <= '0;
            credit_q <= CREDIT_W'(`TRACE_CREDITS);
        end else begin
            if (pop_o) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
            end else if (word_valid_o) begin
                if (last_word) begin
                    busy_q <= 1'b0;
                end
                idx_q <= idx_q + 1'b1;
            end
            // a sent word and a returned credit may coincide
            case ({word_valid_o, credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge clk_gated) begin
        if (pop_o) begin
            pkt_q <= head_i;
        end
    end

    // spending the last credit stops the stream until one comes back
    a_no_word_without_credit: assert property (
        @(posedge clk_gated) disable iff (!rst_ni)
        word_valid_o && (credit_q == CREDIT_W'(1)) && !credit_i |=> !word_valid_o
    );

    // the receiver never returns more credits than it consumed
    a_credit_bound: assert property (
        @(posedge clk_gated) disable iff (!rst_ni)
        credit_q <= CREDIT_W'(`TRACE_CREDITS)
    );

endmodule

`default_nettype wire

/* source/packet_fifo.sv */
// ========================================
// packet FIFO
// circular buffer for trace packets, drops
// a push while full and flags the overflow
// ========================================
`timescale 1ns/1ns

`default_nettype none

module packet_fifo #(
    parameter type         payload_t = trace_pkg::packet_t,
    parameter int unsigned DEPTH     = 2
) (
    input  logic     clk_gated,
    input  logic     rst_ni,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t head_o,
    output logic     head_valid_o,
    output logic     overflow_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             push_ok;
    logic             overflow_q;

    assign full    = count_q == CNT_W'(DEPTH);
    assign push_ok = push_i && !full;

    assign head_o       = mem_q[rd_ptr_q];
    assign head_valid_o = count_q != '0;
    assign overflow_o   = overflow_q;

    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // sticky until reset
            if (push_i && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_gated) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // the consumer only takes a packet that is really there
    a_pop_when_valid: assert property (
        @(posedge clk_gated) disable iff (!rst_ni)
        pop_i |-> head_valid_o
    );

endmodule

`default_nettype wire

/* source/trace_packetizer.sv */
// ========================================
// trace packetizer
// registers retired instructions, records
// branch outcomes in a map and decides when
// a packet is needed to follow the program
// ========================================
`timescale 1ns/1ns
`include "trace_config.svh"

`default_nettype none

module trace_packetizer (
    input  logic               clk_gated,
    input  logic               rst_ni,
    input  logic               ivalid_i,
    input  logic [31:0]        iaddr_i,
    input  logic [31:0]        instr_i,
    input  logic               compressed_i,
    output trace_pkg::packet_t pkt_o,
    output logic               pkt_valid_o
);

    // retired instruction, one cycle behind the core
    logic                              ivalid_q;
    logic [31:0]                       iaddr_q;
    logic [31:0]                       instr_q;
    logic                              compressed_q;

    // the instruction traced before the current one
    logic [31:0]                       prev_addr_q;
    logic                              prev_compressed_q;
    logic                              prev_branch_q;
    logic                              prev_jalr_q;
    logic                              first_q;

    // branch map and its fill level
    logic [`TRACE_MAP_LEN-1:0]         map_q;
    logic [`TRACE_MAP_LEN-1:0]         map_d;
    logic [trace_pkg::MAP_CNT_W-1:0]   cnt_q;
    logic [trace_pkg::MAP_CNT_W-1:0]   cnt_d;

    logic                              is_branch;
    logic                              is_jalr;
    logic [31:0]                       seq_addr;
    logic                              branch_taken;
    logic                              append_branch;
    logic                              map_full;
    logic                              map_clear;

    logic                              pkt_emit;
    trace_pkg::packet_t                pkt_d;
    trace_pkg::packet_t                pkt_q;
    logic                              pkt_valid_q;

    assign is_branch = instr_q[6:0] == trace_pkg::OPCODE_BRANCH;
    assign is_jalr   = instr_q[6:0] == trace_pkg::OPCODE_JALR;

    // a branch falls through to the next sequential address when not taken
    assign seq_addr      = prev_addr_q + (prev_compressed_q ? 32'd2 : 32'd4);
    assign branch_taken  = iaddr_q != seq_addr;
    assign append_branch = ivalid_q && prev_branch_q;

    always_comb begin
        map_d = map_q;
        cnt_d = cnt_q;
        if (append_branch) begin
            map_d[cnt_q] = branch_taken;
            cnt_d        = cnt_q + 1'b1;
        end
    end

    assign map_full = cnt_d == trace_pkg::MAP_CNT_W'(`TRACE_MAP_LEN);

    // packet decision, full map first, then sync, then the jalr target
    always_comb begin
        pkt_emit          = 1'b0;
        map_clear         = 1'b0;
        pkt_d.format      = trace_pkg::FMT_SYNC;
        pkt_d.branch_cnt  = cnt_d;
        pkt_d.branch_map  = map_d;
        pkt_d.addr        = iaddr_q;
        if (ivalid_q) begin
            if (map_full) begin
                pkt_emit     = 1'b1;
                map_clear    = 1'b1;
                pkt_d.format = trace_pkg::FMT_BRANCH;
            end else if (first_q) begin
                pkt_emit     = 1'b1;
                pkt_d.format = trace_pkg::FMT_SYNC;
            end else if (prev_jalr_q) begin
                // target of an indirect jump cannot be inferred
                pkt_emit     = 1'b1;
                map_clear    = 1'b1;
                pkt_d.format = trace_pkg::FMT_ADDR;
            end
        end
    end

    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            ivalid_q <= 1'b0;
        end else begin
            ivalid_q <= ivalid_i;
        end
    end

    // input payload only moves on a retirement
    always_ff @(posedge clk_gated) begin
        if (ivalid_i) begin
            iaddr_q      <= iaddr_i;
            instr_q      <= instr_i;
            compressed_q <= compressed_i;
        end
    end

    always_ff @(posedge clk_gated, negedge rst_ni) begin
        if (!rst_ni) begin
            first_q       <= 1'b1;
            prev_branch_q <= 1'b0;
            prev_jalr_q   <= 1'b0;
            map_q         <= '0;
            cnt_q         <= '0;
            pkt_valid_q   <= 1'b0;
        end else begin
            pkt_valid_q <= pkt_emit;
            if (ivalid_q) begin
                first_q       <= 1'b0;
                prev_branch_q <= is_branch;
                prev_jalr_q   <= is_jalr;
                if (map_clear) begin
                    map_q <= '0;
                    cnt_q <= '0;
                end else begin
                    map_q <= map_d;
                    cnt_q <= cnt_d;
                end
            end
        end
    end

    always_ff @(posedge clk_gated) begin
        if (ivalid_q) begin
            prev_addr_q       <= iaddr_q;
            prev_compressed_q <= compressed_q;
        end
        if (pkt_emit) begin
            pkt_q <= pkt_d;
        end
    end

    assign pkt_o       = pkt_q;
    assign pkt_valid_o = pkt_valid_q;

    // a full map is always flushed before another branch can be recorded
    a_map_cnt_bound: assert property (
        @(posedge clk_gated) disable iff (!rst_ni)
        cnt_q < trace_pkg::MAP_CNT_W'(`TRACE_MAP_LEN)
    );

endmodule

`default_nettype wire

/* source/trace_pkg.sv */
// ========================================
// trace compressor types
// packet format, packet layout and the
// RISC-V opcodes the packetizer decodes
// ========================================
`include "trace_config.svh"

`default_nettype none

package trace_pkg;

    // width of each word on the output stream
    localparam int unsigned WORD_LEN = 32;

    // branch count field, wide enough for a full map
    localparam int unsigned MAP_CNT_W = $clog2(`TRACE_MAP_LEN + 1);

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    // packet kind, sent in the low bits of the header word
    typedef enum logic [1:0] {
        FMT_SYNC   = 2'd1,
        FMT_BRANCH = 2'd2,
        FMT_ADDR   = 2'd3
    } trace_format_e;

    // one packet as it travels through the buffer
    // branch_map bit i is the i-th recorded branch, 1 when taken
    typedef struct packed {
        trace_format_e             format;
        logic [MAP_CNT_W-1:0]      branch_cnt;
        logic [`TRACE_MAP_LEN-1:0] branch_map;
        logic [31:0]               addr;
    } packet_t;

endpackage

`default_nettype wire

/* source/trace_config.svh */
// ========================================
// trace compressor configuration
// sizes shared by the RTL and the testbench
// ========================================
`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// packets held in the buffer between the
// packetizer and the word streamer
`define TRACE_FIFO_DEPTH 4

// credits the receiver grants at reset,
// also the ceiling of the credit counter
`define TRACE_CREDITS 4

// branch outcomes in a full map, one map word
// carries them with its top bit left clear
`define TRACE_MAP_LEN 31

`endif
